// ==== rtl/cache_pkg.sv ====
package cache_pkg;

	// address and word widths
	localparam int ADDR_LEN = 32;
	localparam int DATA_LEN = 64;
	localparam int STRB_LEN = 8;

	// 16 sets of two ways, 32-byte blocks
	localparam int OFFSET_LEN = 5;
	localparam int INDEX_LEN = 4;
	localparam int SET_NUM = 16;
	localparam int TAG_LEN = 23;
	localparam int WAY_NUM = 2;
	localparam int BANK_PER_WAY = 4;
	localparam int BANK_SEL_LEN = 2;
	localparam int BLOCK_LEN = 256;

	localparam logic [7:0] LFSR_SEED = 8'hb5;

	typedef logic [ADDR_LEN-1:0] addr_t;
	typedef logic [DATA_LEN-1:0] data_t;
	typedef logic [STRB_LEN-1:0] strb_t;
	typedef logic [TAG_LEN-1:0] tag_t;
	typedef logic [INDEX_LEN-1:0] index_t;
	typedef logic [BANK_SEL_LEN-1:0] bank_sel_t;
	typedef logic [WAY_NUM-1:0] way_mask_t;
	// word 0 in the low bits
	typedef logic [BLOCK_LEN-1:0] block_t;

	typedef enum logic {
		op_load,
		op_store
	} req_op_e;

	typedef enum logic [2:0] {
		st_idle,
		st_lookup,
		st_miss,
		st_replace,
		st_refill
	} main_state_e;

	typedef enum logic {
		wr_idle,
		wr_write
	} write_state_e;

endpackage

// ==== rtl/data_bank.sv ====
`timescale 1ns/10ps

module data_bank (
	input  logic clk,
	input  logic rst,
	input  logic en,
	input  logic we,
	input  cache_pkg::index_t addr,
	input  cache_pkg::data_t din,
	input  cache_pkg::strb_t wstrb,
	output cache_pkg::data_t dout
);
	import cache_pkg::*;

	data_t mem [SET_NUM];

	// byte-lane write
	always_ff @(posedge clk) begin
		if (en && we) begin
			for (int b = 0; b < STRB_LEN; b++) begin
				if (wstrb[b]) begin
					mem[addr][b*8 +: 8] <= din[b*8 +: 8];
				end
			end
		end
	end

	// registered read, held until the next read
	always_ff @(posedge clk) begin
		if (rst) begin
			dout <= '0;
		end else if (en && !we) begin
			dout <= mem[addr];
		end
	end

endmodule

// ==== rtl/tag_store.sv ====
`timescale 1ns/10ps

module tag_store (
	input  logic clk,
	input  logic rst,
	input  logic rd_en,
	input  cache_pkg::index_t rd_index,
	input  logic fill_en,
	input  cache_pkg::way_mask_t fill_way,
	input  cache_pkg::index_t fill_index,
	input  cache_pkg::tag_t fill_tag,
	input  logic fill_dirty,
	input  logic dirty_set_en,
	input  cache_pkg::way_mask_t dirty_set_way,
	input  cache_pkg::index_t dirty_set_index,
	output cache_pkg::tag_t way_tag [cache_pkg::WAY_NUM],
	output cache_pkg::way_mask_t way_valid,
	output cache_pkg::way_mask_t way_dirty
);
	import cache_pkg::*;

	tag_t tags [WAY_NUM][SET_NUM];
	logic [SET_NUM-1:0] valid [WAY_NUM];
	logic [SET_NUM-1:0] dirty [WAY_NUM];
	index_t rd_index_q;
	way_mask_t dirty_q;

	always_ff @(posedge clk) begin
		for (int w = 0; w < WAY_NUM; w++) begin
			if (fill_en && fill_way[w]) begin
				tags[w][fill_index] <= fill_tag;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int w = 0; w < WAY_NUM; w++) begin
				valid[w] <= '0;
				dirty[w] <= '0;
			end
		end else begin
			for (int w = 0; w < WAY_NUM; w++) begin
				if (fill_en && fill_way[w]) begin
					valid[w][fill_index] <= 1'b1;
					dirty[w][fill_index] <= fill_dirty;
				end else if (dirty_set_en && dirty_set_way[w]) begin
					dirty[w][dirty_set_index] <= 1'b1;
				end
			end
		end
	end

	// lookup read
	always_ff @(posedge clk) begin
		if (rd_en) begin
			rd_index_q <= rd_index;
			for (int w = 0; w < WAY_NUM; w++) begin
				way_tag[w] <= tags[w][rd_index];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			way_valid <= '0;
			dirty_q <= '0;
		end else if (rd_en) begin
			for (int w = 0; w < WAY_NUM; w++) begin
				way_valid[w] <= valid[w][rd_index];
				dirty_q[w] <= dirty[w][rd_index];
			end
		end
	end

	// a store committed during this lookup already counts as dirty
	assign way_dirty = dirty_q |
		((dirty_set_en && dirty_set_index == rd_index_q) ? dirty_set_way : '0);

	a_fill_onehot: assert property (@(posedge clk) disable iff (rst)
		fill_en |-> $onehot(fill_way));

endmodule

// ==== rtl/victim_select.sv ====
`timescale 1ns/10ps

module victim_select (
	input  logic clk,
	input  logic rst,
	input  cache_pkg::way_mask_t way_dirty,
	output cache_pkg::way_mask_t victim_way
);
	import cache_pkg::*;

	logic [7:0] lfsr;

	// x^8 + x^6 + x^5 + x^4 + 1, steps every cycle
	always_ff @(posedge clk) begin
		if (rst) begin
			lfsr <= LFSR_SEED;
		end else begin
			lfsr <= {lfsr[6:0], lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3]};
		end
	end

	// prefer the clean way, random when both match
	always_comb begin
		case (way_dirty)
			2'b01: victim_way = 2'b10;
			2'b10: victim_way = 2'b01;
			default: victim_way = lfsr[0] ? 2'b10 : 2'b01;
		endcase
	end

endmodule

// ==== rtl/write_buffer.sv ====
`timescale 1ns/10ps

module write_buffer (
	input  logic clk,
	input  logic rst,
	input  logic store_hit,
	input  cache_pkg::way_mask_t hit_way,
	input  cache_pkg::index_t hit_index,
	input  cache_pkg::bank_sel_t hit_bank,
	input  cache_pkg::strb_t hit_strb,
	input  cache_pkg::data_t hit_data,
	output logic busy,
	output cache_pkg::way_mask_t wb_way,
	output cache_pkg::index_t wb_index,
	output cache_pkg::bank_sel_t wb_bank,
	output cache_pkg::strb_t wb_strb,
	output cache_pkg::data_t wb_data
);
	import cache_pkg::*;

	write_state_e state;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= wr_idle;
		end else begin
			case (state)
				wr_idle: begin
					if (store_hit) begin
						state <= wr_write;
					end
				end
				wr_write: begin
					if (!store_hit) begin
						state <= wr_idle;
					end
				end
				default: state <= wr_idle;
			endcase
		end
	end

	// one store hit, written to its bank next cycle
	always_ff @(posedge clk) begin
		if (store_hit) begin
			wb_way <= hit_way;
			wb_index <= hit_index;
			wb_bank <= hit_bank;
			wb_strb <= hit_strb;
			wb_data <= hit_data;
		end
	end

	assign busy = (state == wr_write);

	a_hit_onehot: assert property (@(posedge clk) disable iff (rst)
		store_hit |-> $onehot(hit_way));

endmodule

// ==== rtl/data_array.sv ====
`timescale 1ns/10ps

module data_array (
	input  logic clk,
	input  logic rst,
	input  logic rd_en,
	input  cache_pkg::index_t rd_index,
	input  cache_pkg::bank_sel_t rd_bank,
	input  logic wb_en,
	input  cache_pkg::way_mask_t wb_way,
	input  cache_pkg::index_t wb_index,
	input  cache_pkg::bank_sel_t wb_bank,
	input  cache_pkg::strb_t wb_strb,
	input  cache_pkg::data_t wb_data,
	input  logic fill_en,
	input  cache_pkg::way_mask_t fill_way,
	input  cache_pkg::index_t fill_index,
	input  cache_pkg::bank_sel_t fill_bank,
	input  cache_pkg::data_t fill_data,
	input  logic blk_en,
	input  cache_pkg::way_mask_t blk_way,
	input  cache_pkg::index_t blk_index,
	output cache_pkg::data_t way_word [cache_pkg::WAY_NUM],
	output cache_pkg::block_t blk_data
);
	import cache_pkg::*;

	logic [WAY_NUM*BANK_PER_WAY-1:0] rd_sel;
	logic [WAY_NUM*BANK_PER_WAY-1:0] wb_sel;
	logic [WAY_NUM*BANK_PER_WAY-1:0] fill_sel;
	logic [WAY_NUM*BANK_PER_WAY-1:0] blk_sel;
	data_t bank_dout [WAY_NUM*BANK_PER_WAY];
	bank_sel_t rd_bank_q;
	way_mask_t blk_way_q;

	// bank i is word i % 4 of way i / 4
	for (genvar i = 0; i < WAY_NUM*BANK_PER_WAY; i++) begin : g_bank
		index_t bank_addr;

		assign rd_sel[i] = rd_en && (rd_bank == bank_sel_t'(i % BANK_PER_WAY));
		assign wb_sel[i] = wb_en && wb_way[i / BANK_PER_WAY] &&
			(wb_bank == bank_sel_t'(i % BANK_PER_WAY));
		assign fill_sel[i] = fill_en && fill_way[i / BANK_PER_WAY] &&
			(fill_bank == bank_sel_t'(i % BANK_PER_WAY));
		assign blk_sel[i] = blk_en && blk_way[i / BANK_PER_WAY];

		always_comb begin
			if (wb_sel[i]) begin
				bank_addr = wb_index;
			end else if (fill_sel[i]) begin
				bank_addr = fill_index;
			end else if (blk_sel[i]) begin
				bank_addr = blk_index;
			end else begin
				bank_addr = rd_index;
			end
		end

		data_bank u_bank (
			.clk(clk),
			.rst(rst),
			.en(rd_sel[i] | wb_sel[i] | fill_sel[i] | blk_sel[i]),
			.we(wb_sel[i] | fill_sel[i]),
			.addr(bank_addr),
			.din(wb_sel[i] ? wb_data : fill_data),
			.wstrb(wb_sel[i] ? wb_strb : {STRB_LEN{fill_sel[i]}}),
			.dout(bank_dout[i])
		);
	end

	// remember which banks the last reads went to
	always_ff @(posedge clk) begin
		if (rst) begin
			rd_bank_q <= '0;
			blk_way_q <= '0;
		end else begin
			if (rd_en) begin
				rd_bank_q <= rd_bank;
			end
			if (blk_en) begin
				blk_way_q <= blk_way;
			end
		end
	end

	for (genvar w = 0; w < WAY_NUM; w++) begin : g_way
		assign way_word[w] = bank_dout[w*BANK_PER_WAY + int'(rd_bank_q)];
	end

	always_comb begin
		blk_data = '0;
		for (int w = 0; w < WAY_NUM; w++) begin
			if (blk_way_q[w]) begin
				for (int b = 0; b < BANK_PER_WAY; b++) begin
					blk_data[b*DATA_LEN +: DATA_LEN] = bank_dout[w*BANK_PER_WAY + b];
				end
			end
		end
	end

	a_no_wb_fill_clash: assert property (@(posedge clk) disable iff (rst)
		(wb_sel & fill_sel) == '0);

endmodule

// ==== rtl/cache_ctrl.sv ====
`timescale 1ns/10ps

module cache_ctrl (
	input  logic clk,
	input  logic rst,
	input  logic req_valid,
	input  cache_pkg::req_op_e req_op,
	input  cache_pkg::addr_t req_addr,
	input  cache_pkg::strb_t wstrb,
	input  cache_pkg::data_t wdata,
	output logic addr_ok,
	output logic data_ok,
	output cache_pkg::data_t rdata,
	output logic mem_wr_valid,
	output cache_pkg::addr_t mem_wr_addr,
	output cache_pkg::block_t mem_wr_data,
	input  logic mem_wr_ready,
	output logic mem_rd_valid,
	output cache_pkg::addr_t mem_rd_addr,
	input  logic mem_rd_dvalid,
	input  logic mem_rd_last,
	input  cache_pkg::data_t mem_rd_data,
	output logic tag_rd_en,
	output logic data_rd_en,
	output cache_pkg::index_t rd_index,
	output cache_pkg::bank_sel_t rd_bank,
	input  cache_pkg::tag_t way_tag [cache_pkg::WAY_NUM],
	input  cache_pkg::way_mask_t way_valid,
	input  cache_pkg::way_mask_t way_dirty,
	input  cache_pkg::data_t way_word [cache_pkg::WAY_NUM],
	input  cache_pkg::way_mask_t victim_way,
	output logic fill_en,
	output cache_pkg::way_mask_t fill_way,
	output cache_pkg::index_t fill_index,
	output cache_pkg::bank_sel_t fill_bank,
	output cache_pkg::data_t fill_data,
	output cache_pkg::tag_t fill_tag,
	output logic fill_dirty,
	output logic blk_en,
	output cache_pkg::way_mask_t blk_way,
	output cache_pkg::index_t blk_index,
	input  cache_pkg::block_t blk_data,
	output logic store_hit,
	output cache_pkg::way_mask_t hit_way,
	output cache_pkg::index_t hit_index,
	output cache_pkg::bank_sel_t hit_bank,
	output cache_pkg::strb_t hit_strb,
	output cache_pkg::data_t hit_data,
	input  logic busy,
	input  cache_pkg::index_t wb_index,
	input  cache_pkg::bank_sel_t wb_bank
);
	import cache_pkg::*;

	main_state_e state;
	main_state_e state_nxt;
	tag_t req_tag;
	index_t req_index;
	bank_sel_t req_bank;
	req_op_e rb_op;
	tag_t rb_tag;
	index_t rb_index;
	bank_sel_t rb_bank;
	strb_t rb_strb;
	data_t rb_data;
	way_mask_t mb_way;
	tag_t mb_tag;
	index_t mb_index;
	bank_sel_t beat_cnt;
	logic fill_done;
	logic miss_ok;
	data_t miss_word;
	way_mask_t way_hit;
	logic hit;
	logic raw_conflict;
	logic wb_conflict;
	logic accept;

	assign req_tag = req_addr[ADDR_LEN-1 -: TAG_LEN];
	assign req_index = req_addr[OFFSET_LEN +: INDEX_LEN];
	assign req_bank = req_addr[OFFSET_LEN-BANK_SEL_LEN +: BANK_SEL_LEN];

	always_comb begin
		for (int w = 0; w < WAY_NUM; w++) begin
			way_hit[w] = (state == st_lookup) && way_valid[w] && (way_tag[w] == rb_tag);
		end
	end
	assign hit = |way_hit;

	// load to the word a store hit in lookup is about to write
	assign raw_conflict = hit && (rb_op == op_store) && (req_op == op_load) &&
		({req_tag, req_index, req_bank} == {rb_tag, rb_index, rb_bank});
	// loads need the bank port, stores only clash on the same word
	assign wb_conflict = busy && (req_bank == wb_bank) &&
		((req_op == op_load) || (req_index == wb_index));
	assign addr_ok = !(req_valid && (raw_conflict || wb_conflict)) &&
		((state == st_idle) || hit);
	assign accept = req_valid && addr_ok;

	always_comb begin
		state_nxt = state;
		case (state)
			st_idle: begin
				if (accept) begin
					state_nxt = st_lookup;
				end
			end
			st_lookup: begin
				if (hit) begin
					state_nxt = accept ? st_lookup : st_idle;
				end else if ((victim_way & way_valid & way_dirty) != '0) begin
					state_nxt = st_miss;
				end else begin
					state_nxt = st_refill;
				end
			end
			st_miss: begin
				if (mem_wr_ready) begin
					state_nxt = st_replace;
				end
			end
			st_replace: state_nxt = st_refill;
			st_refill: begin
				if (fill_done) begin
					state_nxt = st_idle;
				end
			end
			default: state_nxt = st_idle;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= st_idle;
		end else begin
			state <= state_nxt;
		end
	end

	// request buffer
	always_ff @(posedge clk) begin
		if (accept) begin
			rb_op <= req_op;
			rb_tag <= req_tag;
			rb_index <= req_index;
			rb_bank <= req_bank;
			rb_strb <= wstrb;
			rb_data <= wdata;
		end
	end

	// miss buffer, taken at the end of a missing lookup
	always_ff @(posedge clk) begin
		if ((state == st_lookup) && !hit) begin
			mb_way <= victim_way;
			mb_tag <= victim_way[1] ? way_tag[1] : way_tag[0];
			mb_index <= rb_index;
		end
	end

	// refill beats, load data_ok one cycle after its word
	always_ff @(posedge clk) begin
		if (rst || (state != st_refill)) begin
			beat_cnt <= '0;
			fill_done <= 1'b0;
			miss_ok <= 1'b0;
		end else begin
			miss_ok <= fill_en && (beat_cnt == rb_bank) && (rb_op == op_load);
			if (fill_en) begin
				beat_cnt <= beat_cnt + 1'b1;
				fill_done <= mem_rd_last;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (fill_en && (beat_cnt == rb_bank)) begin
			miss_word <= mem_rd_data;
		end
	end

	// pending store bytes win over the fetched word
	always_comb begin
		fill_data = mem_rd_data;
		if ((rb_op == op_store) && (beat_cnt == rb_bank)) begin
			for (int b = 0; b < STRB_LEN; b++) begin
				if (rb_strb[b]) begin
					fill_data[b*8 +: 8] = rb_data[b*8 +: 8];
				end
			end
		end
	end

	assign data_ok = ((state == st_lookup) && (hit || (rb_op == op_store))) || miss_ok;
	assign rdata = hit ? (way_hit[1] ? way_word[1] : way_word[0]) : miss_word;

	assign tag_rd_en = accept;
	assign data_rd_en = accept && (req_op == op_load);
	assign rd_index = req_index;
	assign rd_bank = req_bank;

	assign store_hit = hit && (rb_op == op_store);
	assign hit_way = way_hit;
	assign hit_index = rb_index;
	assign hit_bank = rb_bank;
	assign hit_strb = rb_strb;
	assign hit_data = rb_data;

	assign blk_en = (state == st_miss) && mem_wr_ready;
	assign blk_way = mb_way;
	assign blk_index = mb_index;
	assign mem_wr_valid = (state == st_replace);
	assign mem_wr_addr = {mb_tag, mb_index, {OFFSET_LEN{1'b0}}};
	assign mem_wr_data = blk_data;

	assign mem_rd_valid = (state == st_refill) && !fill_done;
	assign mem_rd_addr = {rb_tag, rb_index, {OFFSET_LEN{1'b0}}};
	assign fill_en = mem_rd_valid && mem_rd_dvalid;
	assign fill_way = mb_way;
	assign fill_index = rb_index;
	assign fill_bank = beat_cnt;
	assign fill_tag = rb_tag;
	assign fill_dirty = (rb_op == op_store);

	// the last flag comes with the fourth beat
	a_last_beat: assert property (@(posedge clk) disable iff (rst)
		(fill_en && mem_rd_last) |-> (beat_cnt == bank_sel_t'(BANK_PER_WAY - 1)));

endmodule

// ==== rtl/cache_top.sv ====
`timescale 1ns/10ps

module cache_top (
	input  logic clk,
	input  logic rst,
	input  logic req_valid,
	input  cache_pkg::req_op_e req_op,
	input  cache_pkg::addr_t req_addr,
	input  cache_pkg::strb_t wstrb,
	input  cache_pkg::data_t wdata,
	output logic addr_ok,
	output logic data_ok,
	output cache_pkg::data_t rdata,
	output logic mem_wr_valid,
	output cache_pkg::addr_t mem_wr_addr,
	output cache_pkg::block_t mem_wr_data,
	input  logic mem_wr_ready,
	output logic mem_rd_valid,
	output cache_pkg::addr_t mem_rd_addr,
	input  logic mem_rd_dvalid,
	input  logic mem_rd_last,
	input  cache_pkg::data_t mem_rd_data
);
	import cache_pkg::*;

	// lookup
	logic tag_rd_en;
	logic data_rd_en;
	index_t rd_index;
	bank_sel_t rd_bank;
	tag_t way_tag [WAY_NUM];
	way_mask_t way_valid;
	way_mask_t way_dirty;
	data_t way_word [WAY_NUM];
	way_mask_t victim_way;

	// refill and victim read
	logic fill_en;
	way_mask_t fill_way;
	index_t fill_index;
	bank_sel_t fill_bank;
	data_t fill_data;
	tag_t fill_tag;
	logic fill_dirty;
	logic blk_en;
	way_mask_t blk_way;
	index_t blk_index;
	block_t blk_data;

	// store hits
	logic store_hit;
	way_mask_t hit_way;
	index_t hit_index;
	bank_sel_t hit_bank;
	strb_t hit_strb;
	data_t hit_data;
	logic busy;
	way_mask_t wb_way;
	index_t wb_index;
	bank_sel_t wb_bank;
	strb_t wb_strb;
	data_t wb_data;

	cache_ctrl u_ctrl (.*);

	tag_store u_tag (
		.*,
		.rd_en(tag_rd_en),
		.dirty_set_en(busy),
		.dirty_set_way(wb_way),
		.dirty_set_index(wb_index)
	);

	data_array u_data (
		.*,
		.rd_en(data_rd_en),
		.wb_en(busy)
	);

	write_buffer u_wb (.*);

	victim_select u_victim (.*);

endmodule

// ==== test/cache_checker.sv ====
`timescale 1ns/10ps

module cache_checker (
	input  logic clk,
	input  logic rst,
	input  logic req_valid,
	input  cache_pkg::req_op_e req_op,
	input  cache_pkg::addr_t req_addr,
	input  cache_pkg::strb_t wstrb,
	input  cache_pkg::data_t wdata,
	input  logic addr_ok,
	input  logic data_ok,
	input  cache_pkg::data_t rdata,
	input  logic mem_wr_valid,
	input  cache_pkg::addr_t mem_wr_addr,
	input  cache_pkg::block_t mem_wr_data,
	input  logic mem_wr_ready,
	input  int test_id,
	input  logic chk_lat,
	input  logic done,
	output int err_count,
	output int tests_run,
	output int tests_failed,
	output int pending
);
	import cache_pkg::*;

	// one outstanding response, in request order
	typedef struct packed {
		logic is_store;
		logic lat;
		int id;
		data_t exp_data;
		int unsigned cyc;
	} resp_t;

	data_t shadow [addr_t];
	resp_t resp_q [$];
	int unsigned cycle;
	logic rdy_q;
	int cur_id;
	int test_err;

	// called by the memory model when it creates a word
	task automatic mirror_word(input addr_t a, input data_t v);
		shadow[a] = v;
	endtask

	task automatic value_error(input string msg);
		$display("FAILED %0t: %s", $time, msg);
		err_count++;
		test_err++;
	endtask

	task automatic protocol_error(input string msg);
		$display("error at %0t: %s", $time, msg);
		err_count++;
		test_err++;
	endtask

	task automatic finish_test();
		tests_run++;
		if (test_err != 0) begin
			tests_failed++;
			$display("test %0d: %0d errors", cur_id, test_err);
		end else begin
			$display("test %0d: ok", cur_id);
		end
		test_err = 0;
	endtask

	always @(posedge clk) begin
		resp_t r;
		addr_t wa;
		data_t w;
		if (rst) begin
			cycle = 0;
			rdy_q = 1'b1;
			cur_id = 0;
			test_err = 0;
			err_count = 0;
			tests_run = 0;
			tests_failed = 0;
			pending <= 0;
		end else begin
			cycle++;
			// responses before new requests of the same edge
			if (data_ok) begin
				if (resp_q.size() == 0) begin
					protocol_error("data_ok came with no request outstanding");
				end else begin
					r = resp_q.pop_front();
					if (!r.is_store && rdata !== r.exp_data) begin
						value_error($sformatf("test %0d load returned %h, expected %h",
							r.id, rdata, r.exp_data));
					end
					if ((r.is_store || r.lat) && cycle != r.cyc + 1) begin
						value_error($sformatf("test %0d data_ok %0d cycles after acceptance",
							r.id, cycle - r.cyc));
					end
				end
			end
			if (mem_wr_valid) begin
				if (!rdy_q) begin
					protocol_error("write-back was issued while mem_wr_ready was low");
				end
				for (int b = 0; b < BANK_PER_WAY; b++) begin
					wa = mem_wr_addr + addr_t'(b * 8);
					w = mem_wr_data[b*DATA_LEN +: DATA_LEN];
					if (!shadow.exists(wa)) begin
						protocol_error($sformatf("write-back to unknown address %h", wa));
					end else if (w !== shadow[wa]) begin
						value_error($sformatf("write-back word %h is %h, expected %h",
							wa, w, shadow[wa]));
					end
				end
			end
			rdy_q = mem_wr_ready;
			if (req_valid && addr_ok) begin
				if (test_id != cur_id) begin
					if (cur_id != 0) begin
						finish_test();
					end
					cur_id = test_id;
				end
				wa = {req_addr[ADDR_LEN-1:3], 3'b000};
				if (!shadow.exists(wa)) begin
					protocol_error($sformatf("request to address %h with no memory value", wa));
					shadow[wa] = '0;
				end
				w = shadow[wa];
				if (req_op == op_store) begin
					for (int b = 0; b < STRB_LEN; b++) begin
						if (wstrb[b]) begin
							w[b*8 +: 8] = wdata[b*8 +: 8];
						end
					end
					shadow[wa] = w;
				end
				r.is_store = (req_op == op_store);
				r.lat = chk_lat;
				r.id = test_id;
				r.exp_data = w;
				r.cyc = cycle;
				resp_q.push_back(r);
			end
			if (done && cur_id != 0) begin
				finish_test();
				cur_id = 0;
			end
			pending <= resp_q.size();
		end
	end

endmodule

// ==== test/tb_cache.sv ====
`timescale 1ns/10ps

module tb_cache;
	import cache_pkg::*;

	localparam int ACCEPT_TIMEOUT = 300;
	localparam int DRAIN_TIMEOUT = 300;

	typedef struct packed {
		int id;
		req_op_e op;
		addr_t addr;
		data_t wdata;
		strb_t wstrb;
		int wr_delay;
		logic lat;
	} stim_t;

	logic clk = 1'b0;
	logic rst;
	logic req_valid;
	req_op_e req_op;
	addr_t req_addr;
	strb_t wstrb;
	data_t wdata;
	logic addr_ok;
	logic data_ok;
	data_t rdata;
	logic mem_wr_valid;
	addr_t mem_wr_addr;
	block_t mem_wr_data;
	logic mem_wr_ready = 1'b1;
	logic mem_rd_valid;
	addr_t mem_rd_addr;
	logic mem_rd_dvalid = 1'b0;
	logic mem_rd_last = 1'b0;
	data_t mem_rd_data = '0;

	// side information for the checker
	int test_id;
	int cur_delay;
	logic chk_lat;
	logic done;
	int err_count;
	int tests_run;
	int tests_failed;
	int pending;

	stim_t stim [$];
	data_t mem [addr_t];
	int wr_hold;
	int rd_beat;
	int rd_gap;
	logic rd_drop;
	addr_t beat_addr;
	logic timed_out;
	int waited;

	always #5 clk = ~clk;

	cache_top dut0 (.*);

	cache_checker chk0 (.*);

	task automatic add_stim(input int id, input req_op_e op, input addr_t addr,
		input data_t wd, input strb_t ws, input int wr_delay, input logic lat);
		stim_t e;
		e.id = id;
		e.op = op;
		e.addr = addr;
		e.wdata = wd;
		e.wstrb = ws;
		e.wr_delay = wr_delay;
		e.lat = lat;
		stim.push_back(e);
	endtask

	task automatic build_table();
		// cold miss, then hits in the same block
		add_stim(1, op_load, 32'h0000_1000, '0, '0, 0, 1'b0);
		add_stim(2, op_load, 32'h0000_1008, '0, '0, 0, 1'b1);
		add_stim(2, op_load, 32'h0000_1018, '0, '0, 0, 1'b1);
		add_stim(2, op_load, 32'h0000_1000, '0, '0, 0, 1'b1);
		// store hit followed straight by a load of the same word
		add_stim(3, op_store, 32'h0000_1010, 64'h0000_0000_a5a5_5a5a, 8'h0f, 0, 1'b1);
		add_stim(3, op_load, 32'h0000_1010, '0, '0, 0, 1'b1);
		add_stim(3, op_store, 32'h0000_1000, 64'hc3d2_e1f0_0000_0000, 8'hf0, 0, 1'b1);
		add_stim(3, op_load, 32'h0000_1000, '0, '0, 0, 1'b1);
		// store miss into set 1
		add_stim(4, op_store, 32'h0000_2028, 64'h0000_7e81_9a6b_0000, 8'h3c, 0, 1'b1);
		add_stim(4, op_load, 32'h0000_2028, '0, '0, 0, 1'b1);
		add_stim(4, op_load, 32'h0000_2030, '0, '0, 0, 1'b1);
		// three blocks in set 2
		add_stim(5, op_store, 32'h0000_3040, 64'h1111_2222_3333_4444, 8'hff, 0, 1'b1);
		add_stim(5, op_store, 32'h0000_3248, 64'h5555_6666_7777_8888, 8'hff, 0, 1'b1);
		add_stim(5, op_store, 32'h0000_3450, 64'hee00_0000_0000_0077, 8'h81, 0, 1'b1);
		add_stim(5, op_load, 32'h0000_3450, '0, '0, 0, 1'b1);
		add_stim(5, op_load, 32'h0000_3040, '0, '0, 0, 1'b0);
		add_stim(5, op_load, 32'h0000_3248, '0, '0, 0, 1'b0);
		// eviction in set 3 against a slow write port
		add_stim(6, op_store, 32'h0000_5060, 64'h0123_4567_89ab_cdef, 8'hff, 0, 1'b1);
		add_stim(6, op_store, 32'h0000_5268, 64'h0000_00c0_ffee_0000, 8'h3c, 0, 1'b1);
		add_stim(6, op_store, 32'h0000_5470, 64'h00be_ef00_0000_0000, 8'h60, 30, 1'b1);
		add_stim(6, op_load, 32'h0000_5060, '0, '0, 0, 1'b0);
		add_stim(6, op_load, 32'h0000_5268, '0, '0, 0, 1'b0);
		add_stim(6, op_load, 32'h0000_5470, '0, '0, 0, 1'b0);
		add_stim(6, op_load, 32'h0000_1000, '0, '0, 0, 1'b0);
		add_stim(6, op_load, 32'h0000_1010, '0, '0, 0, 1'b0);
		add_stim(6, op_load, 32'h0000_2028, '0, '0, 0, 1'b0);
		add_stim(6, op_load, 32'h0000_3450, '0, '0, 0, 1'b0);
	endtask

	// random contents on first touch, mirrored into the checker
	task automatic touch_word(input addr_t a);
		data_t v;
		if (!mem.exists(a)) begin
			v = {$urandom, $urandom};
			mem[a] = v;
			chk0.mirror_word(a, v);
		end
	endtask

	task automatic touch_block(input addr_t a);
		addr_t base;
		base = {a[ADDR_LEN-1:OFFSET_LEN], {OFFSET_LEN{1'b0}}};
		for (int b = 0; b < BANK_PER_WAY; b++) begin
			touch_word(base + addr_t'(b * 8));
		end
	endtask

	// memory model
	always @(posedge clk) begin
		if (rst) begin
			foreach (stim[i]) begin
				touch_block(stim[i].addr);
			end
			wr_hold <= 0;
			rd_beat <= 0;
			rd_gap <= 0;
			rd_drop <= 1'b0;
			mem_wr_ready <= 1'b1;
			mem_rd_dvalid <= 1'b0;
			mem_rd_last <= 1'b0;
		end else begin
			// write port held off for the accepted entry's delay
			if (req_valid && addr_ok) begin
				wr_hold <= cur_delay;
				mem_wr_ready <= (cur_delay == 0);
			end else if (wr_hold > 1) begin
				wr_hold <= wr_hold - 1;
			end else begin
				wr_hold <= 0;
				mem_wr_ready <= 1'b1;
			end
			if (mem_wr_valid) begin
				for (int b = 0; b < BANK_PER_WAY; b++) begin
					mem[mem_wr_addr + addr_t'(b * 8)] = mem_wr_data[b*DATA_LEN +: DATA_LEN];
				end
			end
			// refill beats with random gaps
			mem_rd_dvalid <= 1'b0;
			mem_rd_last <= 1'b0;
			if (rd_drop) begin
				if (!mem_rd_valid) begin
					rd_drop <= 1'b0;
				end
			end else if (mem_rd_valid) begin
				if (rd_gap != 0) begin
					rd_gap <= rd_gap - 1;
				end else begin
					beat_addr = mem_rd_addr + addr_t'(rd_beat * 8);
					touch_word(beat_addr);
					mem_rd_dvalid <= 1'b1;
					mem_rd_data <= mem[beat_addr];
					mem_rd_last <= (rd_beat == BANK_PER_WAY - 1);
					rd_gap <= int'($urandom % 3);
					if (rd_beat == BANK_PER_WAY - 1) begin
						rd_beat <= 0;
						rd_drop <= 1'b1;
					end else begin
						rd_beat <= rd_beat + 1;
					end
				end
			end
		end
	end

	initial begin
		stim_t e;
		logic got;
		logic keep;
		rst <= 1'b1;
		req_valid <= 1'b0;
		req_op <= op_load;
		req_addr <= '0;
		wstrb <= '0;
		wdata <= '0;
		test_id <= 0;
		cur_delay <= 0;
		chk_lat <= 1'b0;
		done <= 1'b0;
		timed_out = 1'b0;
		void'($urandom(32'h4d88));
		build_table();
		repeat (4) @(posedge clk);
		rst <= 1'b0;

		for (int i = 0; i < stim.size() && !timed_out; i++) begin
			e = stim[i];
			req_valid <= 1'b1;
			req_op <= e.op;
			req_addr <= e.addr;
			wstrb <= e.wstrb;
			wdata <= e.wdata;
			test_id <= e.id;
			cur_delay <= e.wr_delay;
			chk_lat <= e.lat;
			waited = 0;
			do begin
				@(posedge clk);
				got = addr_ok;
				waited++;
			end while (!got && waited < ACCEPT_TIMEOUT);
			if (i + 1 >= stim.size()) begin
				keep = 1'b0;
			end else begin
				keep = (stim[i+1].id == e.id);
			end
			if (!got) begin
				$display("timeout: request %0d of test %0d was not accepted in %0d cycles",
					i, e.id, ACCEPT_TIMEOUT);
				timed_out = 1'b1;
			end else if (!keep) begin
				req_valid <= 1'b0;
				@(posedge clk);
			end
		end
		req_valid <= 1'b0;

		// let the last responses come back
		if (!timed_out) begin
			waited = 0;
			do begin
				@(posedge clk);
				waited++;
			end while (pending != 0 && waited < DRAIN_TIMEOUT);
			if (pending != 0) begin
				$display("timeout: %0d responses still outstanding after %0d cycles",
					pending, DRAIN_TIMEOUT);
				timed_out = 1'b1;
			end
		end
		done <= 1'b1;
		repeat (3) @(posedge clk);
		$display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, err_count);
		if (!timed_out && tests_failed == 0 && err_count == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

// ==== all.f ====
rtl/cache_pkg.sv
rtl/data_bank.sv
rtl/tag_store.sv
rtl/victim_select.sv
rtl/write_buffer.sv
rtl/data_array.sv
rtl/cache_ctrl.sv
rtl/cache_top.sv
test/cache_checker.sv
test/tb_cache.sv

// ==== Makefile ====
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module tb_cache -f all.f -o sim_cache

run: compile
	./obj_dir/sim_cache > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TEST FAIL" $(LOG) || ! grep -q "TEST PASS" $(LOG); then \
		echo "simulation failed"; exit 1; \
	fi
	@echo "simulation passed"

clean:
	rm -rf obj_dir $(LOG)
